// File: rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // ======================================================================
    // Widths and opcodes
    // ======================================================================
    parameter int xlen       = 32;
    parameter int reg_addr_w = 5;

    parameter logic [6:0] opcode_r     = 7'b0110011;
    parameter logic [6:0] opcode_i     = 7'b0010011;
    parameter logic [6:0] opcode_load  = 7'b0000011;
    parameter logic [6:0] opcode_store = 7'b0100011;

    // ALU operation encoding
    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_sll = 4'd5,
        alu_srl = 4'd6,
        alu_sra = 4'd7
    } alu_op_t;

    // ======================================================================
    // Stage payloads
    // ======================================================================

    // Decode to execute
    typedef struct packed {
        logic [xlen-1:0]       rs1_val;
        logic [xlen-1:0]       rs2_val;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] rd;
        alu_op_t               alu_op;
        logic                  alu_src;    // Immediate as operand b
        logic                  mem_read;
        logic                  mem_write;
        logic                  reg_write;
    } id_ex_t;

    // Execute to memory
    typedef struct packed {
        logic [xlen-1:0]       alu_result; // Also the memory address
        logic [xlen-1:0]       store_data;
        logic [reg_addr_w-1:0] rd;
        logic                  mem_read;
        logic                  mem_write;
        logic                  reg_write;
    } ex_mem_t;

    // Memory to writeback
    typedef struct packed {
        logic [xlen-1:0]       wb_data;
        logic [reg_addr_w-1:0] rd;
        logic                  reg_write;  // Already cleared for x0
    } mem_wb_t;

endpackage

`default_nettype wire

// File: rtl/stage_reg.sv
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     in_valid,
    input  payload_t in,
    output logic     out_valid,
    output payload_t out
);

    // Valid flag, cleared on reset
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Payload follows every cycle
    always_ff @(posedge clk) begin
        out <= in;
    end

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`default_nettype none

module reg_file (
    input  logic                          clk,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic                          we,
    input  logic [rv_pkg::reg_addr_w-1:0] wr_addr,
    input  logic [rv_pkg::xlen-1:0]       wr_data,
    output logic [rv_pkg::xlen-1:0]       rs1_data,
    output logic [rv_pkg::xlen-1:0]       rs2_data
);

    logic [rv_pkg::xlen-1:0] regs [2**rv_pkg::reg_addr_w];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // x0 reads zero, same-cycle write is bypassed to decode
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else if (we && wr_addr == rs1_addr) begin
            rs1_data = wr_data;
        end else begin
            rs1_data = regs[rs1_addr];
        end
        if (rs2_addr == '0) begin
            rs2_data = '0;
        end else if (we && wr_addr == rs2_addr) begin
            rs2_data = wr_data;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

    // Memory stage drops reg_write for x0, so no write ever targets it
    a_no_x0_write: assert property (@(posedge clk) !(we && wr_addr == '0));

endmodule

`default_nettype wire

// File: rtl/decode_control.sv
`default_nettype none

module decode_control (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          in_valid,
    input  logic [rv_pkg::xlen-1:0]       instr,
    input  logic [rv_pkg::xlen-1:0]       rs1_data,
    input  logic [rv_pkg::xlen-1:0]       rs2_data,
    output logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
    output logic                          out_valid,
    output rv_pkg::id_ex_t                out
);

    localparam logic [2:0] funct3_word = 3'b010;     // LW and SW
    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000; // SUB, SRA, SRAI

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [rv_pkg::xlen-1:0] imm_i;
    logic [rv_pkg::xlen-1:0] imm_s;
    logic                    is_imm;
    logic                    supported;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign is_imm   = (opcode == rv_pkg::opcode_i);

    // Sign-extended immediates
    assign imm_i = {{(rv_pkg::xlen-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(rv_pkg::xlen-12){instr[31]}}, instr[31:25], instr[11:7]};

    always_comb begin
        supported     = 1'b0;
        out.rs1_val   = rs1_data;
        out.rs2_val   = rs2_data;
        out.imm       = imm_i;
        out.rd        = instr[11:7];
        out.alu_op    = rv_pkg::alu_add;
        out.alu_src   = 1'b0;
        out.mem_read  = 1'b0;
        out.mem_write = 1'b0;
        out.reg_write = 1'b0;
        case (opcode)
            rv_pkg::opcode_r, rv_pkg::opcode_i: begin
                out.reg_write = 1'b1;
                out.alu_src   = is_imm;
                // funct7 only matters for R-type and the immediate shifts
                case (funct3)
                    3'b000: begin
                        if (is_imm || funct7 == funct7_base) begin
                            supported = 1'b1;
                        end else if (funct7 == funct7_alt) begin
                            supported  = 1'b1;
                            out.alu_op = rv_pkg::alu_sub;
                        end
                    end
                    3'b001: begin
                        supported  = (funct7 == funct7_base);
                        out.alu_op = rv_pkg::alu_sll;
                    end
                    3'b100: begin
                        supported  = is_imm || (funct7 == funct7_base);
                        out.alu_op = rv_pkg::alu_xor;
                    end
                    3'b101: begin
                        supported  = (funct7 == funct7_base) || (funct7 == funct7_alt);
                        out.alu_op = (funct7 == funct7_alt) ? rv_pkg::alu_sra
                                                            : rv_pkg::alu_srl;
                    end
                    3'b110: begin
                        supported  = is_imm || (funct7 == funct7_base);
                        out.alu_op = rv_pkg::alu_or;
                    end
                    3'b111: begin
                        supported  = is_imm || (funct7 == funct7_base);
                        out.alu_op = rv_pkg::alu_and;
                    end
                    default: supported = 1'b0;        // SLT, SLTU
                endcase
            end
            rv_pkg::opcode_load: begin
                supported     = (funct3 == funct3_word);
                out.alu_src   = 1'b1;
                out.mem_read  = 1'b1;
                out.reg_write = 1'b1;
            end
            rv_pkg::opcode_store: begin
                supported     = (funct3 == funct3_word);
                out.imm       = imm_s;
                out.alu_src   = 1'b1;
                out.mem_write = 1'b1;
            end
            default: supported = 1'b0;                // Becomes a bubble
        endcase
    end

    assign out_valid = in_valid && supported;

    // A live slot coming out of the fetch register is fully driven
    a_instr_known: assert property (@(posedge clk) disable iff (!reset_n)
        in_valid |-> !$isunknown(instr));

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`default_nettype none

module execute_stage (
    input  logic            in_valid,
    input  rv_pkg::id_ex_t  in,
    output logic            out_valid,
    output rv_pkg::ex_mem_t out
);

    logic [rv_pkg::xlen-1:0] op_a;
    logic [rv_pkg::xlen-1:0] op_b;
    logic [4:0]              shamt;
    logic [rv_pkg::xlen-1:0] result;

    assign op_a  = in.rs1_val;
    assign op_b  = in.alu_src ? in.imm : in.rs2_val;
    assign shamt = op_b[4:0];                          // Low 5 bits only

    // ======================================================================
    // ALU
    // ======================================================================
    always_comb begin
        case (in.alu_op)
            rv_pkg::alu_add: result = op_a + op_b;        // Also LW/SW address
            rv_pkg::alu_sub: result = op_a - op_b;
            rv_pkg::alu_and: result = op_a & op_b;
            rv_pkg::alu_or:  result = op_a | op_b;
            rv_pkg::alu_xor: result = op_a ^ op_b;
            rv_pkg::alu_sll: result = op_a << shamt;
            rv_pkg::alu_srl: result = op_a >> shamt;
            rv_pkg::alu_sra: result = $signed(op_a) >>> shamt;
            default:         result = '0;
        endcase
    end

    assign out.alu_result = result;
    assign out.store_data = in.rs2_val;                // SW data is rs2
    assign out.rd         = in.rd;
    assign out.mem_read   = in.mem_read;
    assign out.mem_write  = in.mem_write;
    assign out.reg_write  = in.reg_write;
    assign out_valid      = in_valid;

endmodule

`default_nettype wire

// File: rtl/mem_access.sv
`default_nettype none

module mem_access #(
    parameter int dmem_depth = 256
) (
    input  logic                    clk,
    input  logic                    in_valid,
    input  rv_pkg::ex_mem_t         in,
    output logic                    out_valid,
    output rv_pkg::mem_wb_t         out,
    output logic                    store_valid,
    output logic [rv_pkg::xlen-1:0] store_addr,
    output logic [rv_pkg::xlen-1:0] store_data
);

    localparam int idx_w = $clog2(dmem_depth);

    logic [rv_pkg::xlen-1:0] dmem [dmem_depth];
    logic [idx_w-1:0]        word_idx;
    logic [rv_pkg::xlen-1:0] load_data;

    assign word_idx = in.alu_result[idx_w+1:2];        // Word addressed

    // Store commits at the end of the memory cycle
    always_ff @(posedge clk) begin
        if (in_valid && in.mem_write) begin
            dmem[word_idx] <= in.store_data;
        end
    end

    assign load_data = dmem[word_idx];                 // Combinational read

    assign out.wb_data   = in.mem_read ? load_data : in.alu_result;
    assign out.rd        = in.rd;
    assign out.reg_write = in.reg_write && (in.rd != '0);
    assign out_valid     = in_valid;

    assign store_valid = in_valid && in.mem_write;
    assign store_addr  = in.alu_result;
    assign store_data  = in.store_data;

    // Address built in execute must land on a word inside the array
    a_addr_ok: assert property (@(posedge clk)
        in_valid && (in.mem_read || in.mem_write) |->
            in.alu_result[1:0] == 2'b00 && in.alu_result[rv_pkg::xlen-1:2] < dmem_depth);

endmodule

`default_nettype wire

// File: rtl/rv_pipeline_top.sv
`default_nettype none

module rv_pipeline_top #(
    parameter int dmem_depth = 256
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          instr_valid,
    input  logic [rv_pkg::xlen-1:0]       instr,
    output logic                          wb_valid,
    output logic [rv_pkg::reg_addr_w-1:0] wb_rd,
    output logic [rv_pkg::xlen-1:0]       wb_data,
    output logic                          store_valid,
    output logic [rv_pkg::xlen-1:0]       store_addr,
    output logic [rv_pkg::xlen-1:0]       store_data
);

    // Stage boundaries, _d before the register and _q after it
    logic                          if_id_valid;
    logic [rv_pkg::xlen-1:0]       if_id_instr;
    logic                          id_ex_valid_d;
    rv_pkg::id_ex_t                id_ex_d;
    logic                          id_ex_valid_q;
    rv_pkg::id_ex_t                id_ex_q;
    logic                          ex_mem_valid_d;
    rv_pkg::ex_mem_t               ex_mem_d;
    logic                          ex_mem_valid_q;
    rv_pkg::ex_mem_t               ex_mem_q;
    logic                          mem_wb_valid_d;
    rv_pkg::mem_wb_t               mem_wb_d;
    logic                          mem_wb_valid_q;
    rv_pkg::mem_wb_t               mem_wb_q;
    logic [rv_pkg::reg_addr_w-1:0] rs1_addr;
    logic [rv_pkg::reg_addr_w-1:0] rs2_addr;
    logic [rv_pkg::xlen-1:0]       rs1_data;
    logic [rv_pkg::xlen-1:0]       rs2_data;

    // ======================================================================
    // Fetch capture and decode
    // ======================================================================
    stage_reg #(.payload_t(logic [rv_pkg::xlen-1:0])) if_id_reg (
        .clk(clk), .reset_n(reset_n),
        .in_valid(instr_valid), .in(instr),
        .out_valid(if_id_valid), .out(if_id_instr)
    );

    decode_control decode_i (
        .clk(clk), .reset_n(reset_n),
        .in_valid(if_id_valid), .instr(if_id_instr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .out_valid(id_ex_valid_d), .out(id_ex_d)
    );

    reg_file reg_file_i (
        .clk(clk),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .we(wb_valid), .wr_addr(wb_rd), .wr_data(wb_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    // ======================================================================
    // Execute, memory, writeback
    // ======================================================================
    stage_reg #(.payload_t(rv_pkg::id_ex_t)) id_ex_reg (
        .clk(clk), .reset_n(reset_n),
        .in_valid(id_ex_valid_d), .in(id_ex_d),
        .out_valid(id_ex_valid_q), .out(id_ex_q)
    );

    execute_stage execute_i (
        .in_valid(id_ex_valid_q), .in(id_ex_q),
        .out_valid(ex_mem_valid_d), .out(ex_mem_d)
    );

    stage_reg #(.payload_t(rv_pkg::ex_mem_t)) ex_mem_reg (
        .clk(clk), .reset_n(reset_n),
        .in_valid(ex_mem_valid_d), .in(ex_mem_d),
        .out_valid(ex_mem_valid_q), .out(ex_mem_q)
    );

    mem_access #(.dmem_depth(dmem_depth)) mem_access_i (
        .clk(clk),
        .in_valid(ex_mem_valid_q), .in(ex_mem_q),
        .out_valid(mem_wb_valid_d), .out(mem_wb_d),
        .store_valid(store_valid), .store_addr(store_addr), .store_data(store_data)
    );

    stage_reg #(.payload_t(rv_pkg::mem_wb_t)) mem_wb_reg (
        .clk(clk), .reset_n(reset_n),
        .in_valid(mem_wb_valid_d), .in(mem_wb_d),
        .out_valid(mem_wb_valid_q), .out(mem_wb_q)
    );

    assign wb_valid = mem_wb_valid_q && mem_wb_q.reg_write; // x0 already dropped
    assign wb_rd    = mem_wb_q.rd;
    assign wb_data  = mem_wb_q.wb_data;

endmodule

`default_nettype wire

// File: verif/tb_rv_pipeline.sv
`default_nettype none

module tb_rv_pipeline;

    localparam int clk_period     = 100;
    localparam int drive_delay    = 10;
    localparam int reset_cycles   = 5;
    localparam int settle_slots   = 10;
    localparam int preamble_slots = 31;
    localparam int directed_slots = 16;
    localparam int random_slots   = 300;
    localparam int drain_cycles   = 8;
    localparam int rand_seed      = 92930;
    localparam int watchdog_time  = (reset_cycles + settle_slots + preamble_slots
        + directed_slots + random_slots + drain_cycles + 20) * clk_period;

    // Outcome kinds from the reference model
    localparam logic [1:0] res_none  = 2'd0;
    localparam logic [1:0] res_wb    = 2'd1;
    localparam logic [1:0] res_store = 2'd2;

    logic        clk = 1'b0;
    logic        reset_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        store_valid;
    logic [31:0] store_addr;
    logic [31:0] store_data;

    int cycle = 0;
    int slot  = 0;
    int mismatch_errors = 0;
    int other_errors    = 0;

    // Architectural state of the reference model
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [logic [31:0]];
    int          last_write [32];

    // Pending results, oldest first
    int          wb_due_q[$];
    logic [4:0]  wb_rd_q[$];
    logic [31:0] wb_data_q[$];
    string       wb_name_q[$];
    int          st_due_q[$];
    logic [31:0] st_addr_q[$];
    logic [31:0] st_data_q[$];
    string       st_name_q[$];

    string      r_name [8] = '{"ADD", "SUB", "SLL", "XOR", "SRL", "SRA", "OR", "AND"};
    logic [2:0] r_f3   [8] = '{3'b000, 3'b000, 3'b001, 3'b100, 3'b101, 3'b101, 3'b110, 3'b111};
    logic [6:0] r_f7   [8] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
    string      i_name [7] = '{"ADDI", "SLLI", "XORI", "SRLI", "SRAI", "ORI", "ANDI"};
    logic [2:0] i_f3   [7] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b101, 3'b110, 3'b111};
    logic [6:0] i_f7   [7] = '{7'h00, 7'h00, 7'h00, 7'h00, 7'h20, 7'h00, 7'h00};

    rv_pipeline_top #(.dmem_depth(256)) dut_i (
        .clk(clk), .reset_n(reset_n),
        .instr_valid(instr_valid), .instr(instr),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .store_valid(store_valid), .store_addr(store_addr), .store_data(store_data)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ======================================================================
    // Encoders and reference model
    // ======================================================================
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), rv_pkg::opcode_r};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input int rs1,
                                          input logic [2:0] f3, input int rd,
                                          input logic [6:0] opc);
        return {imm, 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input int rs2, input int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], rv_pkg::opcode_store};
    endfunction

    function automatic logic [31:0] alu_ref(input rv_pkg::alu_op_t op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            rv_pkg::alu_sub: return a - b;
            rv_pkg::alu_and: return a & b;
            rv_pkg::alu_or:  return a | b;
            rv_pkg::alu_xor: return a ^ b;
            rv_pkg::alu_sll: return a << b[4:0];
            rv_pkg::alu_srl: return a >> b[4:0];
            rv_pkg::alu_sra: return $signed(a) >>> b[4:0];
            default:         return a + b;
        endcase
    endfunction

    // Returns {kind, rd, addr, data} for one instruction against the model state
    function automatic logic [70:0] expected_result(input logic [31:0] ins);
        logic [6:0]      opc;
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic [4:0]      rd;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     imm_i;
        logic [31:0]     imm_s;
        logic            is_i;
        logic            ok;
        rv_pkg::alu_op_t op;
        opc   = ins[6:0];
        f3    = ins[14:12];
        f7    = ins[31:25];
        rd    = ins[11:7];
        a     = model_regs[ins[19:15]];
        b     = model_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        is_i  = (opc == rv_pkg::opcode_i);
        ok    = 1'b0;
        op    = rv_pkg::alu_add;
        if (opc == rv_pkg::opcode_r || is_i) begin
            case (f3)
                3'b000: begin
                    ok = is_i || f7 == 7'h00 || f7 == 7'h20;
                    op = (!is_i && f7 == 7'h20) ? rv_pkg::alu_sub : rv_pkg::alu_add;
                end
                3'b001: begin
                    ok = (f7 == 7'h00);
                    op = rv_pkg::alu_sll;
                end
                3'b100: begin
                    ok = is_i || f7 == 7'h00;
                    op = rv_pkg::alu_xor;
                end
                3'b101: begin
                    ok = (f7 == 7'h00 || f7 == 7'h20);
                    op = (f7 == 7'h20) ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                end
                3'b110: begin
                    ok = is_i || f7 == 7'h00;
                    op = rv_pkg::alu_or;
                end
                3'b111: begin
                    ok = is_i || f7 == 7'h00;
                    op = rv_pkg::alu_and;
                end
                default: ok = 1'b0;                    // SLT, SLTU
            endcase
            if (ok && rd != 5'd0) begin
                return {res_wb, rd, 32'h0, alu_ref(op, a, is_i ? imm_i : b)};
            end
        end else if (opc == rv_pkg::opcode_load && f3 == 3'b010) begin
            if (rd != 5'd0) begin
                return {res_wb, rd, 32'h0, model_mem[a + imm_i]};
            end
        end else if (opc == rv_pkg::opcode_store && f3 == 3'b010) begin
            return {res_store, 5'd0, a + imm_s, b};
        end
        return {res_none, 5'd0, 64'h0};
    endfunction

    // Source is safe once its producer is three slots old
    function automatic bit ready(input int r);
        return (r == 0) || (slot - last_write[r] >= 3);
    endfunction

    // ======================================================================
    // Stimulus
    // ======================================================================
    task automatic issue(input logic [31:0] ins, input string name);
        logic [70:0] res;
        logic [4:0]  rd;
        logic [31:0] addr;
        logic [31:0] data;
        @(posedge clk);
        #drive_delay;
        res  = expected_result(ins);
        rd   = res[68:64];
        addr = res[63:32];
        data = res[31:0];
        if (res[70:69] == res_wb) begin
            model_regs[rd] = data;
            last_write[rd] = slot;
            wb_due_q.push_back(cycle + 4);             // Writeback stage
            wb_rd_q.push_back(rd);
            wb_data_q.push_back(data);
            wb_name_q.push_back(name);
        end else if (res[70:69] == res_store) begin
            model_mem[addr] = data;
            st_due_q.push_back(cycle + 3);             // Memory stage
            st_addr_q.push_back(addr);
            st_data_q.push_back(data);
            st_name_q.push_back(name);
        end
        instr       = ins;
        instr_valid = 1'b1;
        slot++;
    endtask

    task automatic bubble();
        @(posedge clk);
        #drive_delay;
        instr_valid = 1'b0;
        // Idle slots still carry a real ADDI or SW word
        if (slot % 2 == 0) begin
            instr = enc_i(12'hfff, 0, 3'b000, 31, rv_pkg::opcode_i);
        end else begin
            instr = enc_s(12'h000, 31, 0);
        end
        slot++;
    endtask

    task automatic random_slot();
        int          pick;
        int          op;
        int          rs1;
        int          rs2;
        int          rd;
        int          base;
        logic [11:0] imm;
        logic [11:0] off;
        logic [31:0] addr;
        logic [31:0] junk;
        pick = int'($urandom_range(0, 19));
        op   = int'($urandom_range(0, 6));
        rs1  = int'($urandom_range(0, 31));
        rs2  = int'($urandom_range(0, 31));
        rd   = int'($urandom_range(3, 31));        // x1 and x2 stay as bases
        if ($urandom_range(0, 15) == 0) begin
            rd = 0;
        end
        base = int'($urandom_range(1, 2));
        off  = (base == 1) ? 12'(4 * int'($urandom_range(0, 31)))
                           : 12'(4 * int'($urandom_range(0, 31)) - 64);
        addr = model_regs[base] + {{20{off[11]}}, off};
        junk = $urandom();
        if (pick < 8) begin
            if (ready(rs1) && ready(rs2)) begin
                issue(enc_r(r_f7[pick], rs2, rs1, r_f3[pick], rd), r_name[pick]);
            end else begin
                bubble();
            end
        end else if (pick < 14) begin
            imm = 12'($urandom());
            if (i_f3[op] == 3'b001 || i_f3[op] == 3'b101) begin
                imm = {i_f7[op], 5'(rs2)};             // Shift amount field
            end
            if (ready(rs1)) begin
                issue(enc_i(imm, rs1, i_f3[op], rd, rv_pkg::opcode_i), i_name[op]);
            end else begin
                bubble();
            end
        end else if (pick < 18) begin
            // Loads only from words the model has stored
            if (pick >= 16 && model_mem.exists(addr)) begin
                issue(enc_i(off, base, 3'b010, rd, rv_pkg::opcode_load), "LW");
            end else if (ready(rs2)) begin
                issue(enc_s(off, rs2, base), "SW");
            end else begin
                bubble();
            end
        end else if (pick == 18) begin
            junk[6:0] = 7'b1100011;                    // Branch opcode
            issue(junk, "branch");
        end else begin
            bubble();
        end
    endtask

    // ======================================================================
    // Comparison
    // ======================================================================
    task automatic check_writeback();
        int          due;
        logic [4:0]  rd;
        logic [31:0] data;
        string       name;
        if (wb_valid) begin
            assert (wb_due_q.size() > 0) else begin
                $display("Writeback to x%0d at cycle %0d that no instruction expects",
                         wb_rd, cycle);
                other_errors++;
            end
            if (wb_due_q.size() > 0) begin
                due  = wb_due_q.pop_front();
                rd   = wb_rd_q.pop_front();
                data = wb_data_q.pop_front();
                name = wb_name_q.pop_front();
                assert (due == cycle) else begin
                    $display("Mismatch %s cycle: expected %0d actual %0d", name, due, cycle);
                    mismatch_errors++;
                end
                assert (wb_rd == rd) else begin
                    $display("Mismatch %s rd: expected %0d actual %0d", name, rd, wb_rd);
                    mismatch_errors++;
                end
                assert (wb_data == data) else begin
                    $display("Mismatch %s data: expected %h actual %h", name, data, wb_data);
                    mismatch_errors++;
                end
            end
        end else if (wb_due_q.size() > 0) begin
            assert (wb_due_q[0] > cycle) else begin
                $display("%s to x%0d did not write back in cycle %0d",
                         wb_name_q[0], wb_rd_q[0], wb_due_q[0]);
                other_errors++;
                void'(wb_due_q.pop_front());
                void'(wb_rd_q.pop_front());
                void'(wb_data_q.pop_front());
                void'(wb_name_q.pop_front());
            end
        end
    endtask

    task automatic check_store();
        int          due;
        logic [31:0] addr;
        logic [31:0] data;
        string       name;
        if (store_valid) begin
            assert (st_due_q.size() > 0) else begin
                $display("Store to %h at cycle %0d that no instruction expects",
                         store_addr, cycle);
                other_errors++;
            end
            if (st_due_q.size() > 0) begin
                due  = st_due_q.pop_front();
                addr = st_addr_q.pop_front();
                data = st_data_q.pop_front();
                name = st_name_q.pop_front();
                assert (due == cycle) else begin
                    $display("Mismatch %s cycle: expected %0d actual %0d", name, due, cycle);
                    mismatch_errors++;
                end
                assert (store_addr == addr) else begin
                    $display("Mismatch %s addr: expected %h actual %h", name, addr, store_addr);
                    mismatch_errors++;
                end
                assert (store_data == data) else begin
                    $display("Mismatch %s data: expected %h actual %h", name, data, store_data);
                    mismatch_errors++;
                end
            end
        end else if (st_due_q.size() > 0) begin
            assert (st_due_q[0] > cycle) else begin
                $display("%s to %h did not appear in cycle %0d",
                         st_name_q[0], st_addr_q[0], st_due_q[0]);
                other_errors++;
                void'(st_due_q.pop_front());
                void'(st_addr_q.pop_front());
                void'(st_data_q.pop_front());
                void'(st_name_q.pop_front());
            end
        end
    endtask

    always @(negedge clk) begin                        // Outputs settled mid-cycle
        if (reset_n) begin
            check_writeback();
            check_store();
        end
    end

    // ======================================================================
    // Main sequence and watchdog
    // ======================================================================
    initial begin
        void'($urandom(rand_seed));
        reset_n     = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
            last_write[r] = -100;
        end
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        reset_n = 1'b1;

        repeat (settle_slots) bubble();                // Idle, nothing may come out

        // Bases for memory, then every other register
        issue(enc_i(12'h000, 0, 3'b000, 1, rv_pkg::opcode_i), "ADDI base");
        issue(enc_i(12'h200, 0, 3'b000, 2, rv_pkg::opcode_i), "ADDI base");
        for (int r = 3; r < 32; r++) begin
            issue(enc_i(12'($urandom()), 0, 3'b000, r, rv_pkg::opcode_i), "ADDI init");
        end

        // Back to back chain, each consumer exactly three slots behind
        issue(enc_i(12'(-1000), 0, 3'b000, 3, rv_pkg::opcode_i), "ADDI negative");
        issue(enc_i(12'd3, 0, 3'b000, 4, rv_pkg::opcode_i), "ADDI");
        issue(enc_i(12'hfff, 0, 3'b100, 6, rv_pkg::opcode_i), "XORI");
        issue(enc_i({7'h20, 5'd3}, 3, 3'b101, 5, rv_pkg::opcode_i), "SRAI");
        issue(enc_r(7'h00, 4, 4, 3'b001, 7), "SLL");
        issue(enc_r(7'h00, 4, 6, 3'b101, 8), "SRL");
        issue(enc_r(7'h20, 3, 5, 3'b000, 9), "SUB");
        issue(enc_s(12'd8, 3, 1), "SW");
        issue(enc_i(12'd8, 1, 3'b010, 10, rv_pkg::opcode_load), "LW");
        issue(enc_r(7'h00, 4, 3, 3'b000, 0), "ADD x0");
        issue(enc_i(12'h7ff, 0, 3'b111, 11, rv_pkg::opcode_i), "ANDI x0 source");
        issue(32'h00208463, "branch");
        issue(enc_r(7'h00, 4, 3, 3'b010, 12), "SLT");
        issue(enc_r(7'h01, 4, 3, 3'b000, 13), "MUL");
        issue(enc_r(7'h20, 4, 3, 3'b101, 12), "SRA");
        issue(enc_r(7'h00, 9, 10, 3'b110, 13), "OR");

        repeat (random_slots) random_slot();
        repeat (drain_cycles) bubble();                // Last writeback lands after 4

        assert (wb_due_q.size() == 0 && st_due_q.size() == 0) else begin
            $display("%0d writebacks and %0d stores were still pending at the end",
                     wb_due_q.size(), st_due_q.size());
            other_errors++;
        end
        $display("Errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_time);
        $display("Timeout after %0d time units, the run did not complete", watchdog_time);
        other_errors++;
        $display("Errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
rtl/rv_pkg.sv
rtl/stage_reg.sv
rtl/reg_file.sv
rtl/decode_control.sv
rtl/execute_stage.sv
rtl/mem_access.sv
rtl/rv_pipeline_top.sv
verif/tb_rv_pipeline.sv

// File: Makefile
# Verilator build for the pipeline testbench
VERILATOR ?= verilator
TOP       ?= tb_rv_pipeline
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
